/* hw/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int isa_width = 32;

    // ========================================================================
    // Encoding constants
    // ========================================================================
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_word = 3'b010;  // lw, sw
    localparam logic [2:0] f3_half = 3'b001;  // sh
    localparam logic [2:0] f3_add  = 3'b000;  // add, sub, addi, jalr
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_sr   = 3'b101;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;  // sub, srai

    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    // ========================================================================
    // Instruction identity
    // ========================================================================
    typedef enum logic [4:0] {
        inst_invalid, inst_auipc, inst_jal, inst_jalr, inst_beq, inst_bne,
        inst_lw, inst_sh, inst_sw, inst_addi, inst_sltiu, inst_srai,
        inst_add, inst_sub, inst_sltu, inst_xor, inst_or, inst_ebreak
    } inst_num_e;

    typedef enum logic [2:0] {
        type_r, type_i, type_s, type_b, type_u, type_j, type_n
    } inst_type_e;

    typedef enum logic [1:0] {
        wb_alu, wb_mem, wb_pc4, wb_imm_pc
    } wb_sel_e;

    // Format views of one instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_word_u;

    // ========================================================================
    // Core records
    // ========================================================================
    typedef struct packed {
        inst_num_e             inst_num;
        inst_type_e            inst_type;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
        logic [isa_width-1:0]  imm;
        logic                  reg_we;
        logic                  alu_src_imm;
        logic                  mem_re;
        logic                  mem_we;
        wb_sel_e               wb_sel;
    } decode_t;

    typedef struct packed {
        logic                 valid;
        logic [isa_width-1:0] pc;
        logic                 rd_we;
        logic [4:0]           rd;
        logic [isa_width-1:0] rd_data;
    } commit_t;

    typedef struct packed {
        logic [isa_width-1:0] addr;
        logic                 we;
        logic [3:0]           be;
        logic [isa_width-1:0] wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

/* hw/inst_decoder.sv */
`default_nettype none

module inst_decoder (
    input  rv_pkg::inst_word_u inst,
    output rv_pkg::decode_t    dec
);

    rv_pkg::inst_num_e  num;
    rv_pkg::inst_type_e fmt;
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;

    assign opcode = inst.r_fmt.opcode;
    assign funct3 = inst.r_fmt.funct3;
    assign funct7 = inst.r_fmt.funct7;

    always_comb begin : match_inst
        num = rv_pkg::inst_invalid;
        case (opcode)
            rv_pkg::opc_auipc: num = rv_pkg::inst_auipc;
            rv_pkg::opc_jal:   num = rv_pkg::inst_jal;
            rv_pkg::opc_jalr: begin
                if (funct3 == rv_pkg::f3_add) num = rv_pkg::inst_jalr;
            end
            rv_pkg::opc_branch: begin
                if (funct3 == rv_pkg::f3_beq) num = rv_pkg::inst_beq;
                if (funct3 == rv_pkg::f3_bne) num = rv_pkg::inst_bne;
            end
            rv_pkg::opc_load: begin
                if (funct3 == rv_pkg::f3_word) num = rv_pkg::inst_lw;
            end
            rv_pkg::opc_store: begin
                if (funct3 == rv_pkg::f3_half) num = rv_pkg::inst_sh;
                if (funct3 == rv_pkg::f3_word) num = rv_pkg::inst_sw;
            end
            rv_pkg::opc_op_imm: begin
                if (funct3 == rv_pkg::f3_add)  num = rv_pkg::inst_addi;
                if (funct3 == rv_pkg::f3_sltu) num = rv_pkg::inst_sltiu;
                if (funct3 == rv_pkg::f3_sr && funct7 == rv_pkg::f7_alt) begin
                    num = rv_pkg::inst_srai;
                end
            end
            rv_pkg::opc_op: begin
                case ({funct7, funct3})
                    {rv_pkg::f7_base, rv_pkg::f3_add}:  num = rv_pkg::inst_add;
                    {rv_pkg::f7_alt,  rv_pkg::f3_add}:  num = rv_pkg::inst_sub;
                    {rv_pkg::f7_base, rv_pkg::f3_sltu}: num = rv_pkg::inst_sltu;
                    {rv_pkg::f7_base, rv_pkg::f3_xor}:  num = rv_pkg::inst_xor;
                    {rv_pkg::f7_base, rv_pkg::f3_or}:   num = rv_pkg::inst_or;
                    default: ;
                endcase
            end
            rv_pkg::opc_system: begin
                if (inst == rv_pkg::ebreak_word) num = rv_pkg::inst_ebreak;
            end
            default: ;
        endcase
    end

    always_comb begin : match_type
        case (num)
            rv_pkg::inst_add, rv_pkg::inst_sub, rv_pkg::inst_sltu,
            rv_pkg::inst_xor, rv_pkg::inst_or:                 fmt = rv_pkg::type_r;
            rv_pkg::inst_jalr, rv_pkg::inst_lw, rv_pkg::inst_addi,
            rv_pkg::inst_sltiu, rv_pkg::inst_srai:             fmt = rv_pkg::type_i;
            rv_pkg::inst_sh, rv_pkg::inst_sw:                  fmt = rv_pkg::type_s;
            rv_pkg::inst_beq, rv_pkg::inst_bne:                fmt = rv_pkg::type_b;
            rv_pkg::inst_auipc:                                fmt = rv_pkg::type_u;
            rv_pkg::inst_jal:                                  fmt = rv_pkg::type_j;
            default:                                           fmt = rv_pkg::type_n;
        endcase
    end

    always_comb begin : build_dec
        dec           = '0;
        dec.inst_num  = num;
        dec.inst_type = fmt;
        dec.rs1       = inst.r_fmt.rs1;
        dec.rs2       = inst.r_fmt.rs2;
        dec.rd        = inst.r_fmt.rd;

        // Sign-extended immediate per format
        case (fmt)
            rv_pkg::type_i: dec.imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            rv_pkg::type_s: dec.imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5,
                                       inst.s_fmt.imm_4_0};
            rv_pkg::type_b: dec.imm = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11,
                                       inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            rv_pkg::type_u: dec.imm = {inst.u_fmt.imm_31_12, 12'b0};
            rv_pkg::type_j: dec.imm = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12,
                                       inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            default:        dec.imm = '0;
        endcase

        dec.reg_we = (fmt == rv_pkg::type_r) || (fmt == rv_pkg::type_i) ||
                     (fmt == rv_pkg::type_u) || (fmt == rv_pkg::type_j);
        dec.alu_src_imm = (num == rv_pkg::inst_addi) || (num == rv_pkg::inst_sltiu) ||
                          (num == rv_pkg::inst_srai);
        dec.mem_re = (num == rv_pkg::inst_lw);
        dec.mem_we = (num == rv_pkg::inst_sh) || (num == rv_pkg::inst_sw);

        case (num)
            rv_pkg::inst_lw:                     dec.wb_sel = rv_pkg::wb_mem;
            rv_pkg::inst_jal, rv_pkg::inst_jalr: dec.wb_sel = rv_pkg::wb_pc4;
            rv_pkg::inst_auipc:                  dec.wb_sel = rv_pkg::wb_imm_pc;
            default:                             dec.wb_sel = rv_pkg::wb_alu;
        endcase
    end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin : write_port
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // Combinational reads, x0 fixed at zero
    assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

/* hw/alu_unit.sv */
`default_nettype none

module alu_unit (
    input  rv_pkg::inst_num_e                inst_num,
    input  logic [rv_pkg::isa_width-1:0]     op_a,
    input  logic [rv_pkg::isa_width-1:0]     op_b,
    output logic [rv_pkg::isa_width-1:0]     result
);

    logic [rv_pkg::isa_width-1:0] sum;
    logic [rv_pkg::isa_width-1:0] diff;
    logic [rv_pkg::isa_width-1:0] shift_ra;
    logic                         less_u;
    logic                         equal;

    assign sum      = op_a + op_b;
    assign diff     = op_a - op_b;
    assign shift_ra = $signed(op_a) >>> op_b[4:0];  // Only shamt bits count
    assign less_u   = (op_a < op_b);
    assign equal    = (op_a == op_b);

    always_comb begin : select_result
        case (inst_num)
            rv_pkg::inst_add,
            rv_pkg::inst_addi:  result = sum;
            rv_pkg::inst_sub:   result = diff;
            rv_pkg::inst_sltu,
            rv_pkg::inst_sltiu: result = {31'd0, less_u};
            rv_pkg::inst_xor:   result = op_a ^ op_b;
            rv_pkg::inst_or:    result = op_a | op_b;
            rv_pkg::inst_srai:  result = shift_ra;
            // Branch condition in bit 0 for the PC unit
            rv_pkg::inst_beq:   result = {31'd0, equal};
            rv_pkg::inst_bne:   result = {31'd0, ~equal};
            default:            result = sum;
        endcase
    end

endmodule

`default_nettype wire

/* hw/exu_pc.sv */
`default_nettype none

module exu_pc (
    input  rv_pkg::inst_num_e            inst_num,
    input  rv_pkg::inst_type_e           inst_type,
    input  logic [rv_pkg::isa_width-1:0] imm,
    input  logic [rv_pkg::isa_width-1:0] pc,
    input  logic [rv_pkg::isa_width-1:0] src1,
    input  logic [rv_pkg::isa_width-1:0] alu_result,
    output logic [rv_pkg::isa_width-1:0] pc_next,
    output logic                         pc_w_en
);

    logic [rv_pkg::isa_width-1:0] adder_a;
    logic [rv_pkg::isa_width-1:0] adder_b;
    logic [rv_pkg::isa_width-1:0] adder_sum;
    logic                         branch_taken;
    logic                         is_jalr;

    assign branch_taken = alu_result[0];
    assign is_jalr      = (inst_num == rv_pkg::inst_jalr);

    // Default is sequential flow, pc + 4
    always_comb begin : adder_operands
        adder_a = pc;
        adder_b = 32'd4;
        case (inst_num)
            rv_pkg::inst_jal: adder_b = imm;
            rv_pkg::inst_jalr: begin
                adder_a = src1;
                adder_b = imm;
            end
            rv_pkg::inst_beq, rv_pkg::inst_bne: begin
                if (branch_taken) begin
                    adder_b = imm;
                end
            end
            default: ;
        endcase
    end

    assign adder_sum = adder_a + adder_b;
    assign pc_next   = {adder_sum[rv_pkg::isa_width-1:1], adder_sum[0] & ~is_jalr};

    // ebreak and unknown words hold the PC
    assign pc_w_en = (inst_type != rv_pkg::type_n);

endmodule

`default_nettype wire

/* hw/lsu.sv */
`default_nettype none

module lsu (
    input  rv_pkg::decode_t              dec,
    input  logic [rv_pkg::isa_width-1:0] src1,
    input  logic [rv_pkg::isa_width-1:0] src2,
    input  logic [rv_pkg::isa_width-1:0] rdata,
    output rv_pkg::dmem_req_t            req,
    output logic [rv_pkg::isa_width-1:0] load_data
);

    logic [rv_pkg::isa_width-1:0] addr;
    logic                         is_half;

    assign addr    = src1 + dec.imm;
    assign is_half = (dec.inst_num == rv_pkg::inst_sh);

    always_comb begin : build_req
        req.addr = addr;
        req.we   = dec.mem_we;
        if (!dec.mem_we) begin
            req.be = 4'b0000;
        end else if (is_half) begin
            req.be = addr[1] ? 4'b1100 : 4'b0011;  // Upper or lower halfword
        end else begin
            req.be = 4'b1111;
        end
        // Halfword appears in both lanes, byte enables pick one
        if (is_half) begin
            req.wdata = {2{src2[15:0]}};
        end else begin
            req.wdata = src2;
        end
    end

    assign load_data = dec.mem_re ? rdata : '0;  // lw only, full word

endmodule

`default_nettype wire

/* hw/rv_core_top.sv */
`default_nettype none

module rv_core_top #(
    parameter logic [rv_pkg::isa_width-1:0] reset_pc = '0
) (
    input  logic                         clk,
    input  logic                         arst_n,
    output logic [rv_pkg::isa_width-1:0] imem_addr,
    input  logic [rv_pkg::isa_width-1:0] imem_data,
    output rv_pkg::dmem_req_t            dmem_req,
    input  logic [rv_pkg::isa_width-1:0] dmem_rdata,
    output rv_pkg::commit_t              commit,
    output logic                         halted
);

    logic [rv_pkg::isa_width-1:0] pc;
    logic [rv_pkg::isa_width-1:0] pc_next;
    logic                         pc_w_en;
    rv_pkg::inst_word_u           inst_word;
    rv_pkg::decode_t              dec;
    logic [rv_pkg::isa_width-1:0] src1;
    logic [rv_pkg::isa_width-1:0] src2;
    logic [rv_pkg::isa_width-1:0] alu_b;
    logic [rv_pkg::isa_width-1:0] alu_result;
    rv_pkg::dmem_req_t            lsu_req;
    logic [rv_pkg::isa_width-1:0] load_data;
    logic [rv_pkg::isa_width-1:0] wb_data;
    logic                         core_active;

    // ========================================================================
    // PC and halt state
    // ========================================================================
    always_ff @(posedge clk or negedge arst_n) begin : pc_reg
        if (!arst_n) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else if (!halted) begin
            if (pc_w_en) begin
                pc <= pc_next;
            end
            if (dec.inst_type == rv_pkg::type_n) begin
                halted <= 1'b1;  // Sticky until reset
            end
        end
    end

    assign core_active = arst_n & ~halted;
    assign imem_addr   = pc;
    assign inst_word   = imem_data;

    // ========================================================================
    // Datapath
    // ========================================================================
    inst_decoder decoder_i (.inst(inst_word), .dec(dec));

    reg_file reg_file_i (
        .clk   (clk),
        .arst_n(arst_n),
        .rs1   (dec.rs1),
        .rs2   (dec.rs2),
        .rd    (dec.rd),
        .we    (dec.reg_we & core_active),
        .wdata (wb_data),
        .rdata1(src1),
        .rdata2(src2)
    );

    assign alu_b = dec.alu_src_imm ? dec.imm : src2;

    alu_unit alu_i (.inst_num(dec.inst_num), .op_a(src1), .op_b(alu_b), .result(alu_result));

    exu_pc exu_pc_i (
        .inst_num  (dec.inst_num),
        .inst_type (dec.inst_type),
        .imm       (dec.imm),
        .pc        (pc),
        .src1      (src1),
        .alu_result(alu_result),
        .pc_next   (pc_next),
        .pc_w_en   (pc_w_en)
    );

    lsu lsu_i (
        .dec      (dec),
        .src1     (src1),
        .src2     (src2),
        .rdata    (dmem_rdata),
        .req      (lsu_req),
        .load_data(load_data)
    );

    always_comb begin : writeback_mux
        case (dec.wb_sel)
            rv_pkg::wb_mem:    wb_data = load_data;
            rv_pkg::wb_pc4:    wb_data = pc + 32'd4;  // Link address
            rv_pkg::wb_imm_pc: wb_data = pc + dec.imm;
            default:           wb_data = alu_result;
        endcase
    end

    always_comb begin : outputs
        dmem_req    = lsu_req;
        dmem_req.we = lsu_req.we & core_active;

        commit.valid   = core_active;
        commit.pc      = pc;
        commit.rd_we   = dec.reg_we & core_active;
        commit.rd      = dec.rd;
        commit.rd_data = wb_data;
    end

endmodule

`default_nettype wire

/* testbench/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Program image placed at reset_pc, one instruction word per entry
localparam int num_words = 30;

localparam logic [31:0] program_words [num_words] = '{
    32'h0050_0093,  // 40  addi  x1, x0, 5
    32'hff80_0113,  // 44  addi  x2, x0, -8
    32'h0020_81b3,  // 48  add   x3, x1, x2
    32'h4020_8233,  // 4c  sub   x4, x1, x2
    32'h0020_b2b3,  // 50  sltu  x5, x1, x2
    32'h0011_3333,  // 54  sltu  x6, x2, x1
    32'h0060_b393,  // 58  sltiu x7, x1, 6
    32'h0041_c433,  // 5c  xor   x8, x3, x4
    32'h0040_e4b3,  // 60  or    x9, x1, x4
    32'h4021_5513,  // 64  srai  x10, x2, 2
    32'h0070_8013,  // 68  addi  x0, x1, 7
    32'h0010_05b3,  // 6c  add   x11, x0, x1
    32'h00b0_8463,  // 70  beq   x1, x11, +8   taken
    32'h0630_0613,  // 74  addi  x12, x0, 99   skipped
    32'h00b0_9463,  // 78  bne   x1, x11, +8   not taken
    32'h0020_9463,  // 7c  bne   x1, x2, +8    taken
    32'h04d0_0613,  // 80  addi  x12, x0, 77   skipped
    32'h0080_06ef,  // 84  jal   x13, +8
    32'h0370_0613,  // 88  addi  x12, x0, 55   skipped
    32'h0000_1717,  // 8c  auipc x14, 0x1
    32'h0a10_0793,  // 90  addi  x15, x0, 0xa1
    32'h0007_8867,  // 94  jalr  x16, 0(x15)   target a0
    32'h00b0_0613,  // 98  addi  x12, x0, 11   skipped
    32'h0160_0613,  // 9c  addi  x12, x0, 22   skipped
    32'h0030_2823,  // a0  sw    x3, 16(x0)
    32'h6b30_0893,  // a4  addi  x17, x0, 0x6b3
    32'h0110_1b23,  // a8  sh    x17, 22(x0)
    32'h0140_2903,  // ac  lw    x18, 20(x0)
    32'h0100_2983,  // b0  lw    x19, 16(x0)
    32'h0010_0073   // b4  ebreak
};

// Columns: pc, rd_we, rd, rd_data, keep_mask, keep_word, mem_we, be
// Bits set in keep_mask come from the initial data memory word keep_word
typedef struct packed {
    logic [31:0] pc;
    logic        rd_we;
    logic [4:0]  rd;
    logic [31:0] rd_data;
    logic [31:0] keep_mask;
    logic [5:0]  keep_word;
    logic        mem_we;
    logic [3:0]  be;
} commit_exp_t;

localparam int num_commits = 25;

localparam commit_exp_t commit_table [num_commits] = '{
    '{32'h0000_0040, 1'b1, 5'd1,  32'h0000_0005, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0044, 1'b1, 5'd2,  32'hffff_fff8, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0048, 1'b1, 5'd3,  32'hffff_fffd, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_004c, 1'b1, 5'd4,  32'h0000_000d, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0050, 1'b1, 5'd5,  32'h0000_0001, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0054, 1'b1, 5'd6,  32'h0000_0000, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0058, 1'b1, 5'd7,  32'h0000_0001, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_005c, 1'b1, 5'd8,  32'hffff_fff0, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0060, 1'b1, 5'd9,  32'h0000_000d, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0064, 1'b1, 5'd10, 32'hffff_fffe, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0068, 1'b1, 5'd0,  32'h0000_000c, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_006c, 1'b1, 5'd11, 32'h0000_0005, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0070, 1'b0, 5'd0,  32'h0000_0000, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0078, 1'b0, 5'd0,  32'h0000_0000, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_007c, 1'b0, 5'd0,  32'h0000_0000, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0084, 1'b1, 5'd13, 32'h0000_0088, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_008c, 1'b1, 5'd14, 32'h0000_108c, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0090, 1'b1, 5'd15, 32'h0000_00a1, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_0094, 1'b1, 5'd16, 32'h0000_0098, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_00a0, 1'b0, 5'd0,  32'h0000_0000, 32'h0000_0000, 6'd0, 1'b1, 4'hf},
    '{32'h0000_00a4, 1'b1, 5'd17, 32'h0000_06b3, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_00a8, 1'b0, 5'd0,  32'h0000_0000, 32'h0000_0000, 6'd0, 1'b1, 4'hc},
    '{32'h0000_00ac, 1'b1, 5'd18, 32'h06b3_0000, 32'h0000_ffff, 6'd5, 1'b0, 4'h0},
    '{32'h0000_00b0, 1'b1, 5'd19, 32'hffff_fffd, 32'h0000_0000, 6'd0, 1'b0, 4'h0},
    '{32'h0000_00b4, 1'b0, 5'd0,  32'h0000_0000, 32'h0000_0000, 6'd0, 1'b0, 4'h0}
};

// Data memory after the run: word, value, keep_mask
// Words not listed keep their initial contents
typedef struct packed {
    logic [5:0]  word;
    logic [31:0] value;
    logic [31:0] keep_mask;
} mem_exp_t;

localparam int num_mem_checks = 2;

localparam mem_exp_t mem_table [num_mem_checks] = '{
    '{6'd4, 32'hffff_fffd, 32'h0000_0000},
    '{6'd5, 32'h06b3_0000, 32'h0000_ffff}
};

`endif

/* testbench/tb_rv_core.sv */
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] reset_pc     = 32'h0000_0040;
    localparam int          imem_words   = 256;
    localparam int          dmem_words   = 64;
    localparam int          prog_base    = int'(reset_pc[9:2]);
    localparam int          halt_timeout = 1;
    localparam int          idle_cycles  = 10;
    localparam logic [31:0] lcg_seed     = 32'h6301_8a9b;

    `include "tb_program.svh"

    logic              clk;
    logic              arst_n;
    logic [31:0]       imem_addr;
    logic [31:0]       imem_data;
    rv_pkg::dmem_req_t dmem_req;
    logic [31:0]       dmem_rdata;
    rv_pkg::commit_t   commit;
    logic              halted;

    logic [31:0] imem [imem_words];
    logic [31:0] dmem [dmem_words];
    logic [31:0] dmem_init [dmem_words];  // Snapshot for expected values

    rv_core_top #(.reset_pc(reset_pc)) dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dmem_req  (dmem_req),
        .dmem_rdata(dmem_rdata),
        .commit    (commit),
        .halted    (halted)
    );

    always #10 clk = ~clk;

    // ========================================================================
    // Memory models
    // ========================================================================
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_req.addr[7:2]];

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    always @(posedge clk) begin : dmem_write
        if (dmem_req.we) begin
            dmem[dmem_req.addr[7:2]] <= merge_bytes(dmem[dmem_req.addr[7:2]],
                                                    dmem_req.wdata, dmem_req.be);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_memories();
        logic [31:0] state;
        state = lcg_seed;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = '0;  // Invalid word that halts the core
        end
        for (int i = 0; i < num_words; i++) begin
            imem[prog_base + i] = program_words[i];
        end
        for (int i = 0; i < dmem_words; i++) begin
            state        = lcg_next(state);
            dmem[i]     <= state;
            dmem_init[i] = state;
        end
    endtask

    // ========================================================================
    // Checks
    // ========================================================================
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual,
                     expected);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_reset_outputs();
        check_value(imem_addr, reset_pc, "pc in reset");
        check_value(32'(commit.valid), 32'd0, "commit valid in reset");
        check_value(32'(dmem_req.we), 32'd0, "dmem we in reset");
        check_value(32'(halted), 32'd0, "halted in reset");
    endtask

    task automatic check_commit(input int idx);
        commit_exp_t row;
        logic [31:0] exp_data;
        string       tag;
        row      = commit_table[idx];
        exp_data = (row.rd_data & ~row.keep_mask) | (dmem_init[row.keep_word] & row.keep_mask);
        tag      = $sformatf("commit %0d", idx);
        check_value(32'(commit.valid), 32'd1, {tag, " valid"});
        check_value(imem_addr, row.pc, {tag, " imem addr"});
        check_value(commit.pc, row.pc, {tag, " pc"});
        check_value(32'(commit.rd_we), 32'(row.rd_we), {tag, " rd_we"});
        if (row.rd_we) begin
            check_value(32'(commit.rd), 32'(row.rd), {tag, " rd"});
            check_value(commit.rd_data, exp_data, {tag, " rd_data"});
        end
        check_value(32'(dmem_req.we), 32'(row.mem_we), {tag, " dmem we"});
        if (row.mem_we) begin
            check_value(32'(dmem_req.be), 32'(row.be), {tag, " dmem be"});
        end
        check_value(32'(halted), 32'd0, {tag, " halted"});
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (halted !== 1'b1) begin
            if (cycles >= halt_timeout) begin
                $display("Error at %0t ns: core did not halt after ebreak", $time);
                $display("Testbench failed");
                $fatal(1);
            end
            @(posedge clk);
            cycles++;
        end
    endtask

    task automatic check_data_memory();
        logic [31:0] exp_word;
        for (int i = 0; i < dmem_words; i++) begin
            exp_word = dmem_init[i];
            for (int j = 0; j < num_mem_checks; j++) begin
                if (int'(mem_table[j].word) == i) begin
                    exp_word = (mem_table[j].value & ~mem_table[j].keep_mask)
                             | (dmem_init[i] & mem_table[j].keep_mask);
                end
            end
            check_value(dmem[i], exp_word, $sformatf("data memory word %0d", i));
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin : run_test
        logic [31:0] halt_pc;
        clk    = 1'b0;
        arst_n = 1'b1;
        load_memories();
        #1 arst_n = 1'b0;  // Falling edge resets the core before the first clock

        repeat (3) begin
            @(posedge clk);
            check_reset_outputs();
        end
        #2 arst_n = 1'b1;

        for (int r = 0; r < num_commits; r++) begin
            @(posedge clk);
            check_commit(r);
        end

        wait_for_halt();
        halt_pc = commit_table[num_commits-1].pc;
        for (int c = 0; c < idle_cycles; c++) begin
            check_value(imem_addr, halt_pc, "pc after halt");
            check_value(32'(commit.valid), 32'd0, "commit valid after halt");
            check_value(32'(commit.rd_we), 32'd0, "register write after halt");
            check_value(32'(dmem_req.we), 32'd0, "dmem we after halt");
            check_value(32'(halted), 32'd1, "halted");
            @(posedge clk);
        end

        check_data_memory();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+testbench
hw/rv_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/alu_unit.sv
hw/exu_pc.sv
hw/lsu.sv
hw/rv_core_top.sv
testbench/tb_rv_core.sv

/* Makefile */
# Verilator build and run for the single-cycle core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# A $fatal in the testbench gives a nonzero exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
